// File: verilog/fcp_link_config.svh
`ifndef FCP_LINK_CONFIG_SVH
`define FCP_LINK_CONFIG_SVH

// ==========================================================================
// Message field widths
// ==========================================================================
`define FCP_VC_W            16
`define FCP_STAT_W          32
`define FCP_WORD_W          128

// Link buffer and timing
`define FCP_FIFO_DEPTH      16
`define FCP_STARTUP_CYCLES  64
`define FCP_RATE_WINDOW     256

// Rate meter counters
`define FCP_TOTAL_W         64
`define FCP_RATE_W          32

`endif

// File: verilog/fcp_link_pkg.sv
`default_nettype none

`include "fcp_link_config.svh"

package fcp_link_pkg;

    // Virtual-channel index
    typedef logic [`FCP_VC_W-1:0] vc_t;

    // One credit or length field (FCCL, qlen, FCCR)
    typedef logic [`FCP_STAT_W-1:0] stat_t;

    // Link word, from bit 0 up
    // VC, FCCL, qlen, FCCR, then zero padding to the top
    typedef logic [`FCP_WORD_W-1:0] fcp_word_t;

    // Link control states
    typedef enum logic {
        LINK_STARTUP = 1'b0,
        LINK_UP      = 1'b1
    } link_state_t;

endpackage

`default_nettype wire

// File: verilog/fcp_link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module fcp_link_ctrl (
    input  logic user_clk,
    input  logic sys_rst_async,
    input  logic in_valid,
    input  logic fifo_has_room,
    output logic link_up,
    output logic in_ready,
    output logic accept
);

    // Counter must reach FCP_STARTUP_CYCLES itself
    localparam int CNT_W = $clog2(`FCP_STARTUP_CYCLES + 1);

    fcp_link_pkg::link_state_t state;
    logic [CNT_W-1:0]          startup_cnt;

    // ======================================================================
    // Startup timer and link state
    // ======================================================================
    always_ff @(posedge user_clk) begin
        if (sys_rst_async) begin
            state       <= fcp_link_pkg::LINK_STARTUP;
            startup_cnt <= '0;
        end else begin
            case (state)
                fcp_link_pkg::LINK_STARTUP: begin
                    // Link comes up N edges after reset release
                    if (startup_cnt == CNT_W'(`FCP_STARTUP_CYCLES)) begin
                        state <= fcp_link_pkg::LINK_UP;
                    end else begin
                        startup_cnt <= startup_cnt + 1'b1;
                    end
                end
                // Stays up until the next reset
                fcp_link_pkg::LINK_UP: state <= fcp_link_pkg::LINK_UP;
                default:               state <= fcp_link_pkg::LINK_STARTUP;
            endcase
        end
    end

    assign link_up  = (state == fcp_link_pkg::LINK_UP);
    // Room already accounts for a word pending in the packer
    assign in_ready = link_up && fifo_has_room;
    assign accept   = in_valid && in_ready;

endmodule

`default_nettype wire

// File: verilog/fcp_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module fcp_packer (
    input  logic                   user_clk,
    input  logic                   sys_rst_async,
    input  logic                   accept,
    input  fcp_link_pkg::vc_t      in_vc,
    input  fcp_link_pkg::stat_t    in_fccl,
    input  fcp_link_pkg::stat_t    in_qlen,
    input  fcp_link_pkg::stat_t    in_fccr,
    output logic                   wr_en,
    output fcp_link_pkg::fcp_word_t wr_word
);

    // Unused bits above FCCR
    localparam int PAD_W = `FCP_WORD_W - `FCP_VC_W - 3 * `FCP_STAT_W;

    // Write strobe, one cycle per accepted message
    always_ff @(posedge user_clk) begin
        if (sys_rst_async) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= accept;
        end
    end

    // Payload register, loaded only on accept
    always_ff @(posedge user_clk) begin
        if (accept) begin
            // Low end first: VC, FCCL, qlen, FCCR
            wr_word <= {{PAD_W{1'b0}}, in_fccr, in_qlen, in_fccl, in_vc};
        end
    end

endmodule

`default_nettype wire

// File: verilog/fcp_link_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module fcp_link_fifo (
    input  logic                    user_clk,
    input  logic                    sys_rst_async,
    input  logic                    wr_en,
    input  fcp_link_pkg::fcp_word_t wr_word,
    input  logic                    rd_en,
    output fcp_link_pkg::fcp_word_t rd_word,
    output logic                    not_empty,
    output logic                    has_room
);

    localparam int DEPTH = `FCP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int LVL_W = $clog2(DEPTH + 1);

    fcp_link_pkg::fcp_word_t mem [DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [LVL_W-1:0]        level;
    logic                    do_rd;

    // Reads of an empty buffer are ignored
    assign do_rd = rd_en && not_empty;

    // Word storage
    always_ff @(posedge user_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // ======================================================================
    // Pointers and fill level
    // ======================================================================
    always_ff @(posedge user_clk) begin
        if (sys_rst_async) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // First word falls through
    assign rd_word   = mem[rd_ptr];
    assign not_empty = (level != '0);
    // Pending write from the packer counts as taken
    assign has_room  = (int'(level) + int'(wr_en)) < DEPTH;

endmodule

`default_nettype wire

// File: verilog/fcp_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module fcp_unpacker (
    input  logic                    user_clk,
    input  logic                    sys_rst_async,
    input  fcp_link_pkg::fcp_word_t rd_word,
    input  logic                    not_empty,
    output logic                    rd_en,
    input  logic                    out_ready,
    output logic                    out_valid,
    output fcp_link_pkg::vc_t       out_vc,
    output fcp_link_pkg::stat_t     out_fccl,
    output fcp_link_pkg::stat_t     out_qlen,
    output fcp_link_pkg::stat_t     out_fccr,
    output logic                    deliver
);

    // Field offsets inside a link word
    localparam int FCCL_LSB = `FCP_VC_W;
    localparam int QLEN_LSB = FCCL_LSB + `FCP_STAT_W;
    localparam int FCCR_LSB = QLEN_LSB + `FCP_STAT_W;

    fcp_link_pkg::fcp_word_t hold_word;

    // Pull when the register is empty or its word leaves this cycle
    assign rd_en   = not_empty && (!out_valid || out_ready);
    assign deliver = out_valid && out_ready;

    always_ff @(posedge user_clk) begin
        if (sys_rst_async) begin
            out_valid <= 1'b0;
        end else if (rd_en) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Output payload, held while out_ready is low
    always_ff @(posedge user_clk) begin
        if (rd_en) begin
            hold_word <= rd_word;
        end
    end

    // Split into message fields
    assign out_vc   = hold_word[`FCP_VC_W-1:0];
    assign out_fccl = hold_word[FCCL_LSB +: `FCP_STAT_W];
    assign out_qlen = hold_word[QLEN_LSB +: `FCP_STAT_W];
    assign out_fccr = hold_word[FCCR_LSB +: `FCP_STAT_W];

endmodule

`default_nettype wire

// File: verilog/fcp_rate_meter.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module fcp_rate_meter (
    input  logic                    user_clk,
    input  logic                    sys_rst_async,
    input  logic                    link_up,
    input  logic                    deliver,
    output logic [`FCP_TOTAL_W-1:0] total_count,
    output logic [`FCP_RATE_W-1:0]  rate_count,
    output logic                    rate_valid
);

    localparam int WIN_W = $clog2(`FCP_RATE_WINDOW);

    logic [WIN_W-1:0]       win_cnt;
    logic [`FCP_RATE_W-1:0] tally;

    // Running total of deliveries
    always_ff @(posedge user_clk) begin
        if (sys_rst_async) begin
            total_count <= '0;
        end else if (deliver) begin
            total_count <= total_count + 1'b1;
        end
    end

    // ======================================================================
    // Window counter and tally, running only while the link is up
    // ======================================================================
    always_ff @(posedge user_clk) begin
        if (sys_rst_async) begin
            win_cnt    <= '0;
            tally      <= '0;
            rate_count <= '0;
            rate_valid <= 1'b0;
        end else begin
            rate_valid <= 1'b0;
            if (link_up) begin
                if (win_cnt == WIN_W'(`FCP_RATE_WINDOW - 1)) begin
                    // Close the window, last edge's delivery included
                    win_cnt    <= '0;
                    rate_count <= tally + `FCP_RATE_W'(deliver);
                    rate_valid <= 1'b1;
                    tally      <= '0;
                end else begin
                    win_cnt <= win_cnt + 1'b1;
                    tally   <= tally + `FCP_RATE_W'(deliver);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fcp_link_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module fcp_link_top (
    input  logic                    user_clk,
    input  logic                    sys_rst_async,
    // Message in
    input  logic                    in_valid,
    input  fcp_link_pkg::vc_t       in_vc,
    input  fcp_link_pkg::stat_t     in_fccl,
    input  fcp_link_pkg::stat_t     in_qlen,
    input  fcp_link_pkg::stat_t     in_fccr,
    output logic                    in_ready,
    output logic                    link_up,
    // Message out
    input  logic                    out_ready,
    output logic                    out_valid,
    output fcp_link_pkg::vc_t       out_vc,
    output fcp_link_pkg::stat_t     out_fccl,
    output fcp_link_pkg::stat_t     out_qlen,
    output fcp_link_pkg::stat_t     out_fccr,
    // Delivery statistics
    output logic [`FCP_TOTAL_W-1:0] total_count,
    output logic [`FCP_RATE_W-1:0]  rate_count,
    output logic                    rate_valid
);

    // ======================================================================
    // Internal link wires
    // ======================================================================
    logic                    accept;
    logic                    fifo_has_room;
    logic                    wr_en;
    fcp_link_pkg::fcp_word_t wr_word;
    logic                    rd_en;
    fcp_link_pkg::fcp_word_t rd_word;
    logic                    not_empty;
    logic                    deliver;

    // Startup gating and acceptance
    fcp_link_ctrl u_ctrl (
        .user_clk      (user_clk),
        .sys_rst_async (sys_rst_async),
        .in_valid      (in_valid),
        .fifo_has_room (fifo_has_room),
        .link_up       (link_up),
        .in_ready      (in_ready),
        .accept        (accept)
    );

    fcp_packer u_packer (
        .user_clk      (user_clk),
        .sys_rst_async (sys_rst_async),
        .accept        (accept),
        .in_vc         (in_vc),
        .in_fccl       (in_fccl),
        .in_qlen       (in_qlen),
        .in_fccr       (in_fccr),
        .wr_en         (wr_en),
        .wr_word       (wr_word)
    );

    // Models the crossing buffer
    fcp_link_fifo u_fifo (
        .user_clk      (user_clk),
        .sys_rst_async (sys_rst_async),
        .wr_en         (wr_en),
        .wr_word       (wr_word),
        .rd_en         (rd_en),
        .rd_word       (rd_word),
        .not_empty     (not_empty),
        .has_room      (fifo_has_room)
    );

    fcp_unpacker u_unpacker (
        .user_clk      (user_clk),
        .sys_rst_async (sys_rst_async),
        .rd_word       (rd_word),
        .not_empty     (not_empty),
        .rd_en         (rd_en),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_vc        (out_vc),
        .out_fccl      (out_fccl),
        .out_qlen      (out_qlen),
        .out_fccr      (out_fccr),
        .deliver       (deliver)
    );

    fcp_rate_meter u_rate_meter (
        .user_clk      (user_clk),
        .sys_rst_async (sys_rst_async),
        .link_up       (link_up),
        .deliver       (deliver),
        .total_count   (total_count),
        .rate_count    (rate_count),
        .rate_valid    (rate_valid)
    );

endmodule

`default_nettype wire

// File: tests/fcp_link_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module fcp_link_assertions (
    input logic                user_clk,
    input logic                sys_rst_async,
    input logic                in_ready,
    input logic                link_up,
    input logic                accept,
    input logic                deliver,
    input logic                out_valid,
    input logic                out_ready,
    input fcp_link_pkg::vc_t   out_vc,
    input fcp_link_pkg::stat_t out_fccl,
    input fcp_link_pkg::stat_t out_qlen,
    input fcp_link_pkg::stat_t out_fccr
);

    // Assertion failures so far
    int fail_count = 0;

    // Messages accepted and not yet delivered
    int in_flight;

    always_ff @(posedge user_clk) begin
        if (sys_rst_async) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(accept) - int'(deliver);
        end
    end

    // ======================================================================
    // Link-level properties
    // ======================================================================
    // No acceptance before link-up
    ready_needs_link: assert property (
        @(posedge user_clk) disable iff (sys_rst_async) in_ready |-> link_up
    ) else begin
        fail_count++;
        $error("in_ready high while the link is down");
    end

    // Stalled output keeps its word
    stalled_output_holds: assert property (
        @(posedge user_clk) disable iff (sys_rst_async)
        out_valid && !out_ready |=> out_valid && $stable(out_vc) && $stable(out_fccl)
                                    && $stable(out_qlen) && $stable(out_fccr)
    ) else begin
        fail_count++;
        $error("out fields changed while stalled");
    end

    // Link holds at most the FIFO entries plus the output register
    no_accept_when_full: assert property (
        @(posedge user_clk) disable iff (sys_rst_async)
        accept |-> in_flight <= `FCP_FIFO_DEPTH
    ) else begin
        fail_count++;
        $error("message accepted with no room in the FIFO");
    end

endmodule

`default_nettype wire

// File: tests/tb_fcp_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcp_link_config.svh"

module tb_fcp_link;

    localparam int CLK_PERIOD = 8;
    localparam int VC_W       = `FCP_VC_W;
    localparam int STAT_W     = `FCP_STAT_W;
    localparam int WORD_W     = `FCP_WORD_W;
    // Field offsets in a link word from the low end
    localparam int FCCL_LSB   = VC_W;
    localparam int QLEN_LSB   = FCCL_LSB + STAT_W;
    localparam int FCCR_LSB   = QLEN_LSB + STAT_W;

    // Phase lengths in cycles
    localparam int RESET_CYCLES  = 10;
    localparam int STARTUP_LIMIT = `FCP_STARTUP_CYCLES + 10;
    localparam int STREAM_CYCLES = 200;
    localparam int FILL_CYCLES   = 40;
    localparam int STALL_CYCLES  = 20;
    localparam int RAND_CYCLES   = 2000;
    localparam int COUNT_CYCLES  = 4 * `FCP_RATE_WINDOW;
    localparam int DRAIN_LIMIT   = 100;
    localparam int BUDGET_CYCLES = RESET_CYCLES + STARTUP_LIMIT + STREAM_CYCLES
                                 + FILL_CYCLES + STALL_CYCLES + RAND_CYCLES
                                 + COUNT_CYCLES + 4 * (DRAIN_LIMIT + 1);

    logic                     user_clk;
    logic                     sys_rst_async;
    logic                     in_valid;
    fcp_link_pkg::vc_t        in_vc;
    fcp_link_pkg::stat_t      in_fccl;
    fcp_link_pkg::stat_t      in_qlen;
    fcp_link_pkg::stat_t      in_fccr;
    logic                     in_ready;
    logic                     link_up;
    logic                     out_ready;
    logic                     out_valid;
    fcp_link_pkg::vc_t        out_vc;
    fcp_link_pkg::stat_t      out_fccl;
    fcp_link_pkg::stat_t      out_qlen;
    fcp_link_pkg::stat_t      out_fccr;
    logic [`FCP_TOTAL_W-1:0]  total_count;
    logic [`FCP_RATE_W-1:0]   rate_count;
    logic                     rate_valid;

    // Scoreboard state
    fcp_link_pkg::fcp_word_t  exp_q[$];
    fcp_link_pkg::fcp_word_t  head_word;
    fcp_link_pkg::fcp_word_t  held_word;
    int                       seed = 34635;
    int                       error_count = 0;
    int                       errors_before = 0;
    int                       check_count = 0;
    int                       test_count = 0;
    int                       delivered = 0;
    int                       window_count = 0;
    int                       win_edges = 0;
    int                       windows_checked = 0;
    int                       windows_before;
    int                       held_count;
    int                       edges;
    logic                     took_last = 1'b0;

    fcp_link_top UUT (
        .user_clk      (user_clk),
        .sys_rst_async (sys_rst_async),
        .in_valid      (in_valid),
        .in_vc         (in_vc),
        .in_fccl       (in_fccl),
        .in_qlen       (in_qlen),
        .in_fccr       (in_fccr),
        .in_ready      (in_ready),
        .link_up       (link_up),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_vc        (out_vc),
        .out_fccl      (out_fccl),
        .out_qlen      (out_qlen),
        .out_fccr      (out_fccr),
        .total_count   (total_count),
        .rate_count    (rate_count),
        .rate_valid    (rate_valid)
    );

    bind fcp_link_top fcp_link_assertions u_assertions (
        .user_clk      (user_clk),
        .sys_rst_async (sys_rst_async),
        .in_ready      (in_ready),
        .link_up       (link_up),
        .accept        (accept),
        .deliver       (deliver),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_vc        (out_vc),
        .out_fccl      (out_fccl),
        .out_qlen      (out_qlen),
        .out_fccr      (out_fccr)
    );

    always #(CLK_PERIOD / 2) user_clk = ~user_clk;

    // ======================================================================
    // Reference model, checks and stimulus helpers
    // ======================================================================
    // Expected link word with VC, FCCL, qlen and FCCR from bit 0 and zeros above
    function automatic fcp_link_pkg::fcp_word_t pack_message(
        input fcp_link_pkg::vc_t vc, input fcp_link_pkg::stat_t fccl,
        input fcp_link_pkg::stat_t qlen, input fcp_link_pkg::stat_t fccr);
        fcp_link_pkg::fcp_word_t word;
        word                      = '0;
        word[VC_W-1:0]            = vc;
        word[FCCL_LSB +: STAT_W]  = fccl;
        word[QLEN_LSB +: STAT_W]  = qlen;
        word[FCCR_LSB +: STAT_W]  = fccr;
        return word;
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] actual,
                               input logic [WORD_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic int roll_percent();
        return $unsigned($random(seed)) % 100;
    endfunction

    task automatic load_random_fields();
        in_vc   = fcp_link_pkg::vc_t'($random(seed));
        in_fccl = fcp_link_pkg::stat_t'($random(seed));
        in_qlen = fcp_link_pkg::stat_t'($random(seed));
        in_fccr = fcp_link_pkg::stat_t'($random(seed));
    endtask

    // A message stays offered until taken before a new one may follow
    task automatic run_traffic(input int cycles, input int valid_pct, input int ready_pct);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge user_clk);
            out_ready = (roll_percent() < ready_pct);
            if (!in_valid || took_last) begin
                in_valid = (roll_percent() < valid_pct);
                load_random_fields();
            end
        end
    endtask

    // Stop sending and wait for every outstanding message
    task automatic drain_link();
        int n;
        @(negedge user_clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge user_clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("Drain failed: %0d messages were never delivered", exp_q.size());
        end
        @(negedge user_clk);
        check_value("out_valid", out_valid, 0);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // ======================================================================
    // Compare process sampling values before the edge updates them
    // ======================================================================
    always @(posedge user_clk) begin
        if (sys_rst_async) begin
            took_last = 1'b0;
        end else begin
            check_value("total_count", total_count, delivered);
            // Window closed on the previous edge
            if (rate_valid) begin
                check_value("rate_count", rate_count, window_count);
                check_value("rate_valid spacing", win_edges, `FCP_RATE_WINDOW);
                window_count = 0;
                win_edges = 0;
                windows_checked++;
            end
            // Window cycles run from link-up
            if (link_up) begin
                win_edges++;
            end
            took_last = in_valid && in_ready;
            if (took_last) begin
                exp_q.push_back(pack_message(in_vc, in_fccl, in_qlen, in_fccr));
            end
            if (out_valid && out_ready) begin
                delivered++;
                window_count++;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected delivery with no message outstanding at %0t", $time);
                end else begin
                    head_word = exp_q.pop_front();
                    check_value("out_vc", out_vc, head_word[VC_W-1:0]);
                    check_value("out_fccl", out_fccl, head_word[FCCL_LSB +: STAT_W]);
                    check_value("out_qlen", out_qlen, head_word[QLEN_LSB +: STAT_W]);
                    check_value("out_fccr", out_fccr, head_word[FCCR_LSB +: STAT_W]);
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(2 * BUDGET_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        user_clk      = 1'b0;
        sys_rst_async = 1'b1;
        out_ready     = 1'b1;
        // Offered during reset and startup but never taken
        in_valid      = 1'b1;
        load_random_fields();
        repeat (RESET_CYCLES) @(negedge user_clk);
        sys_rst_async = 1'b0;

        // Link held down until the startup count ends
        edges = 0;
        while (!link_up && edges < STARTUP_LIMIT) begin
            @(negedge user_clk);
            edges++;
            if (!link_up) begin
                check_value("in_ready", in_ready, 0);
                check_value("out_valid", out_valid, 0);
                check_value("rate_valid", rate_valid, 0);
            end
        end
        in_valid = 1'b0;
        if (!link_up) begin
            error_count++;
            $display("link_up never rose after reset release");
        end else begin
            // First edge with reset low is edge 1
            check_value("link_up delay", edges - 1, `FCP_STARTUP_CYCLES);
        end
        check_value("exp_q size", exp_q.size(), 0);
        finish_test("startup");

        run_traffic(STREAM_CYCLES, 100, 100);
        drain_link();
        finish_test("streaming");

        // Fill the link with the far end stalled
        run_traffic(FILL_CYCLES, 100, 0);
        check_value("in_ready", in_ready, 0);
        check_value("out_valid", out_valid, 1);
        held_word  = pack_message(out_vc, out_fccl, out_qlen, out_fccr);
        held_count = exp_q.size();
        // FIFO entries plus the output register
        check_value("held messages", held_count, `FCP_FIFO_DEPTH + 1);
        run_traffic(STALL_CYCLES, 100, 0);
        check_value("held output", pack_message(out_vc, out_fccl, out_qlen, out_fccr),
                    held_word);
        check_value("exp_q size", exp_q.size(), held_count);
        drain_link();
        finish_test("back-pressure");

        run_traffic(RAND_CYCLES, 60, 50);
        drain_link();
        finish_test("random traffic");

        // Spans several rate windows
        windows_before = windows_checked;
        run_traffic(COUNT_CYCLES, 70, 80);
        drain_link();
        check_value("total_count", total_count, delivered);
        if (windows_checked - windows_before < 3) begin
            error_count++;
            $display("Only %0d rate windows closed", windows_checked - windows_before);
        end
        finish_test("counters");

        error_count += UUT.u_assertions.fail_count;
        $display("Summary: %0d tests, %0d checks, %0d deliveries, %0d assertion failures, %0d errors",
                 test_count, check_count, delivered, UUT.u_assertions.fail_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/fcp_link_pkg.sv
verilog/fcp_link_ctrl.sv
verilog/fcp_packer.sv
verilog/fcp_link_fifo.sv
verilog/fcp_unpacker.sv
verilog/fcp_rate_meter.sv
verilog/fcp_link_top.sv
tests/fcp_link_assertions.sv
tests/tb_fcp_link.sv
